// File: hw/axi_mem_pkg.sv
// ------------------------------------------------
// Shared definitions for the AXI4 slave memory port
// Holds bus widths, channel payload structs, the
// memory request struct and the FSM/encoding enums
// Modules refer to these by scoped names
// ------------------------------------------------

package axi_mem_pkg;

    // ------------------------------------------------
    // Bus widths
    // ------------------------------------------------
    localparam int unsigned ADDR_WIDTH   = 32;
    localparam int unsigned DATA_WIDTH   = 32;
    localparam int unsigned STRB_WIDTH   = DATA_WIDTH / 8;
    localparam int unsigned ID_WIDTH     = 4;
    localparam int unsigned LEN_WIDTH    = 8;
    // Width of the word address carried to the memory
    localparam int unsigned MEM_ADDR_MAX = 16;

    // Address step between INCR beats, one full word
    localparam logic [ADDR_WIDTH-1:0] BEAT_BYTES = ADDR_WIDTH'(STRB_WIDTH);

    // ------------------------------------------------
    // Encodings
    // ------------------------------------------------
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_DATA = 2'd1,
        WR_RESP = 2'd2
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_REQ  = 2'd1,
        RD_DATA = 2'd2
    } rd_state_e;

    // ------------------------------------------------
    // Channel payloads
    // ------------------------------------------------
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        burst_e                burst;
    } axi_aw_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        burst_e                burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        resp_e               resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        resp_e                 resp;
        logic                  last;
    } axi_r_t;

    // Single-port SRAM request, strobes active low
    typedef struct packed {
        logic                    cen_n;
        logic                    wen_n;
        logic [MEM_ADDR_MAX-1:0] addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic [STRB_WIDTH-1:0]   be;
    } mem_req_t;

endpackage

// File: hw/axi_write_ctrl.sv
// ------------------------------------------------
// AXI4 write channel controller
// Accepts one AW burst at a time, turns every W beat
// into a memory write once the port is granted and
// answers with a single B response per burst
// Out-of-range beats are dropped and flagged SLVERR
// ------------------------------------------------

module axi_write_ctrl #(
    parameter int unsigned MEM_ADDR_WIDTH = 13
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,

    input  axi_mem_pkg::axi_aw_t  aw_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,

    input  axi_mem_pkg::axi_w_t   w_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,

    output axi_mem_pkg::axi_b_t   b_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i,

    output axi_mem_pkg::mem_req_t wr_req_o,
    output logic                  wr_pending_o,
    input  logic                  wr_gnt_i
);

    axi_mem_pkg::wr_state_e                state_q;
    logic [axi_mem_pkg::ID_WIDTH-1:0]      id_q;
    axi_mem_pkg::burst_e                   burst_q;
    logic [axi_mem_pkg::ADDR_WIDTH-1:0]    addr_q;
    logic                                  err_q;
    logic                                  in_range;
    logic                                  beat_done;

    // Beat hits the SRAM only if no address bit above the array is set
    assign in_range  = (addr_q >> (MEM_ADDR_WIDTH + 2)) == '0;
    assign beat_done = w_valid_i && w_ready_o;

    // ------------------------------------------------
    // Channel handshakes
    // ------------------------------------------------
    assign aw_ready_o   = (state_q == axi_mem_pkg::WR_IDLE);
    assign wr_pending_o = (state_q == axi_mem_pkg::WR_DATA) && w_valid_i && in_range;
    // Out-of-range beats are swallowed without waiting for the port
    assign w_ready_o    = (state_q == axi_mem_pkg::WR_DATA) && (in_range ? wr_gnt_i : 1'b1);
    assign b_valid_o    = (state_q == axi_mem_pkg::WR_RESP);

    always_comb
    begin
        b_o.id   = id_q;
        b_o.resp = err_q ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
    end

    // Strobes map straight onto byte enables
    always_comb
    begin
        wr_req_o.cen_n = !wr_pending_o;
        wr_req_o.wen_n = 1'b0;
        wr_req_o.addr  = addr_q[2 +: axi_mem_pkg::MEM_ADDR_MAX];
        wr_req_o.wdata = w_i.data;
        wr_req_o.be    = w_i.strb;
    end

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q <= axi_mem_pkg::WR_IDLE;
            err_q   <= 1'b0;
        end
        else
        begin
            case (state_q)
                axi_mem_pkg::WR_IDLE:
                begin
                    if (aw_valid_i)
                    begin
                        state_q <= axi_mem_pkg::WR_DATA;
                        err_q   <= 1'b0;
                    end
                end
                axi_mem_pkg::WR_DATA:
                begin
                    if (beat_done)
                    begin
                        // Sticky, one bad beat fails the whole burst
                        err_q <= err_q | !in_range;
                        if (w_i.last)
                        begin
                            state_q <= axi_mem_pkg::WR_RESP;
                        end
                    end
                end
                axi_mem_pkg::WR_RESP:
                begin
                    if (b_ready_i)
                    begin
                        state_q <= axi_mem_pkg::WR_IDLE;
                    end
                end
                default:
                begin
                    state_q <= axi_mem_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // Burst context and address walk
    always_ff @(posedge ACLK)
    begin
        if (aw_valid_i && aw_ready_o)
        begin
            id_q    <= aw_i.id;
            burst_q <= aw_i.burst;
            addr_q  <= aw_i.addr;
        end
        else if (beat_done && burst_q == axi_mem_pkg::BURST_INCR)
        begin
            addr_q <= addr_q + axi_mem_pkg::BEAT_BYTES;
        end
    end

endmodule

// File: hw/axi_read_ctrl.sv
// ------------------------------------------------
// AXI4 read channel controller
// Accepts one AR burst at a time and issues one
// memory read per beat when the port is granted
// Each R beat is held in a register until taken,
// so no new read goes out while R is stalled
// ------------------------------------------------

module axi_read_ctrl #(
    parameter int unsigned MEM_ADDR_WIDTH = 13
) (
    input  logic                                ACLK,
    input  logic                                ARESETn,

    input  axi_mem_pkg::axi_ar_t                ar_i,
    input  logic                                ar_valid_i,
    output logic                                ar_ready_o,

    output axi_mem_pkg::axi_r_t                 r_o,
    output logic                                r_valid_o,
    input  logic                                r_ready_i,

    output axi_mem_pkg::mem_req_t               rd_req_o,
    output logic                                rd_pending_o,
    input  logic                                rd_gnt_i,

    input  logic [axi_mem_pkg::DATA_WIDTH-1:0]  mem_rdata_i
);

    axi_mem_pkg::rd_state_e                state_q;
    logic [axi_mem_pkg::ID_WIDTH-1:0]      id_q;
    axi_mem_pkg::burst_e                   burst_q;
    logic [axi_mem_pkg::ADDR_WIDTH-1:0]    addr_q;
    logic [axi_mem_pkg::LEN_WIDTH-1:0]     cnt_q;
    // Set while the granted read data is still on its way back
    logic                                  cap_q;
    axi_mem_pkg::axi_r_t                   r_q;
    logic                                  in_range;
    logic                                  beat_issue;

    assign in_range   = (addr_q >> (MEM_ADDR_WIDTH + 2)) == '0;
    // Beat leaves RD_REQ either by a granted read or by skipping memory
    assign beat_issue = (state_q == axi_mem_pkg::RD_REQ) && (!in_range || rd_gnt_i);

    assign ar_ready_o   = (state_q == axi_mem_pkg::RD_IDLE);
    assign rd_pending_o = (state_q == axi_mem_pkg::RD_REQ) && in_range;
    assign r_valid_o    = (state_q == axi_mem_pkg::RD_DATA) && !cap_q;
    assign r_o          = r_q;

    always_comb
    begin
        rd_req_o.cen_n = !rd_pending_o;
        rd_req_o.wen_n = 1'b1;
        rd_req_o.addr  = addr_q[2 +: axi_mem_pkg::MEM_ADDR_MAX];
        rd_req_o.wdata = '0;
        rd_req_o.be    = '1;
    end

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q <= axi_mem_pkg::RD_IDLE;
            cap_q   <= 1'b0;
        end
        else
        begin
            case (state_q)
                axi_mem_pkg::RD_IDLE:
                begin
                    if (ar_valid_i)
                    begin
                        state_q <= axi_mem_pkg::RD_REQ;
                    end
                end
                axi_mem_pkg::RD_REQ:
                begin
                    if (beat_issue)
                    begin
                        state_q <= axi_mem_pkg::RD_DATA;
                        cap_q   <= in_range;
                    end
                end
                axi_mem_pkg::RD_DATA:
                begin
                    if (cap_q)
                    begin
                        cap_q <= 1'b0;
                    end
                    else if (r_ready_i)
                    begin
                        state_q <= r_q.last ? axi_mem_pkg::RD_IDLE : axi_mem_pkg::RD_REQ;
                    end
                end
                default:
                begin
                    state_q <= axi_mem_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // Burst context, beat counter and the outgoing R register
    always_ff @(posedge ACLK)
    begin
        if (ar_valid_i && ar_ready_o)
        begin
            id_q    <= ar_i.id;
            burst_q <= ar_i.burst;
            addr_q  <= ar_i.addr;
            cnt_q   <= ar_i.len;
        end
        if (beat_issue)
        begin
            r_q.id   <= id_q;
            r_q.last <= (cnt_q == '0);
            r_q.resp <= in_range ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
            r_q.data <= '0;
        end
        if (state_q == axi_mem_pkg::RD_DATA && cap_q)
        begin
            r_q.data <= mem_rdata_i;
        end
        if (r_valid_o && r_ready_i)
        begin
            cnt_q <= cnt_q - 1'b1;
            if (burst_q == axi_mem_pkg::BURST_INCR)
            begin
                addr_q <= addr_q + axi_mem_pkg::BEAT_BYTES;
            end
        end
    end

endmodule

// File: hw/mem_port_arbiter.sv
// ------------------------------------------------
// Round-robin share of the single SRAM port
// Splits the external grant between the write and
// read controllers and drives the winner's request
// Priority toggles after every granted access
// ------------------------------------------------

module mem_port_arbiter (
    input  logic                  ACLK,
    input  logic                  ARESETn,

    input  axi_mem_pkg::mem_req_t wr_req_i,
    input  logic                  wr_pending_i,
    output logic                  wr_gnt_o,

    input  axi_mem_pkg::mem_req_t rd_req_i,
    input  logic                  rd_pending_i,
    output logic                  rd_gnt_o,

    input  logic                  mem_gnt_i,
    output axi_mem_pkg::mem_req_t mem_req_o
);

    // Low selects write priority
    logic rd_prio_q;
    logic rd_sel;

    // Grant goes to the favoured side if it asks, else to the other one
    always_comb
    begin
        wr_gnt_o = 1'b0;
        rd_gnt_o = 1'b0;
        if (rd_prio_q ? rd_pending_i : !wr_pending_i)
        begin
            rd_gnt_o = mem_gnt_i;
        end
        else
        begin
            wr_gnt_o = mem_gnt_i;
        end
    end

    assign rd_sel    = rd_pending_i && (rd_prio_q || !wr_pending_i);
    assign mem_req_o = rd_sel ? rd_req_i : wr_req_i;

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            rd_prio_q <= 1'b0;
        end
        else if (!mem_req_o.cen_n && mem_gnt_i)
        begin
            rd_prio_q <= !rd_prio_q;
        end
    end

endmodule

// File: hw/axi_mem_if_top.sv
// ------------------------------------------------
// AXI4 slave in front of a single-port SRAM whose
// access can be stalled by an external grant
// Write and read controllers share the port via a
// round-robin arbiter; MEM_ADDR_WIDTH sets the
// number of words and must not exceed MEM_ADDR_MAX
// ------------------------------------------------

module axi_mem_if_top #(
    parameter int unsigned MEM_ADDR_WIDTH = 13
) (
    input  logic                               ACLK,
    input  logic                               ARESETn,

    input  axi_mem_pkg::axi_aw_t               aw_i,
    input  logic                               aw_valid_i,
    output logic                               aw_ready_o,

    input  axi_mem_pkg::axi_w_t                w_i,
    input  logic                               w_valid_i,
    output logic                               w_ready_o,

    output axi_mem_pkg::axi_b_t                b_o,
    output logic                               b_valid_o,
    input  logic                               b_ready_i,

    input  axi_mem_pkg::axi_ar_t               ar_i,
    input  logic                               ar_valid_i,
    output logic                               ar_ready_o,

    output axi_mem_pkg::axi_r_t                r_o,
    output logic                               r_valid_o,
    input  logic                               r_ready_i,

    output axi_mem_pkg::mem_req_t              mem_req_o,
    input  logic                               mem_gnt_i,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0] mem_rdata_i
);

    axi_mem_pkg::mem_req_t wr_req;
    axi_mem_pkg::mem_req_t rd_req;
    logic                  wr_pending;
    logic                  rd_pending;
    logic                  wr_gnt;
    logic                  rd_gnt;

    axi_write_ctrl #(
        .MEM_ADDR_WIDTH ( MEM_ADDR_WIDTH )
    ) i_write_ctrl (
        .ACLK         ( ACLK       ),
        .ARESETn      ( ARESETn    ),
        .aw_i         ( aw_i       ),
        .aw_valid_i   ( aw_valid_i ),
        .aw_ready_o   ( aw_ready_o ),
        .w_i          ( w_i        ),
        .w_valid_i    ( w_valid_i  ),
        .w_ready_o    ( w_ready_o  ),
        .b_o          ( b_o        ),
        .b_valid_o    ( b_valid_o  ),
        .b_ready_i    ( b_ready_i  ),
        .wr_req_o     ( wr_req     ),
        .wr_pending_o ( wr_pending ),
        .wr_gnt_i     ( wr_gnt     )
    );

    axi_read_ctrl #(
        .MEM_ADDR_WIDTH ( MEM_ADDR_WIDTH )
    ) i_read_ctrl (
        .ACLK         ( ACLK        ),
        .ARESETn      ( ARESETn     ),
        .ar_i         ( ar_i        ),
        .ar_valid_i   ( ar_valid_i  ),
        .ar_ready_o   ( ar_ready_o  ),
        .r_o          ( r_o         ),
        .r_valid_o    ( r_valid_o   ),
        .r_ready_i    ( r_ready_i   ),
        .rd_req_o     ( rd_req      ),
        .rd_pending_o ( rd_pending  ),
        .rd_gnt_i     ( rd_gnt      ),
        .mem_rdata_i  ( mem_rdata_i )
    );

    mem_port_arbiter i_arbiter (
        .ACLK         ( ACLK       ),
        .ARESETn      ( ARESETn    ),
        .wr_req_i     ( wr_req     ),
        .wr_pending_i ( wr_pending ),
        .wr_gnt_o     ( wr_gnt     ),
        .rd_req_i     ( rd_req     ),
        .rd_pending_i ( rd_pending ),
        .rd_gnt_o     ( rd_gnt     ),
        .mem_gnt_i    ( mem_gnt_i  ),
        .mem_req_o    ( mem_req_o  )
    );

endmodule

// File: dv/tb_axi_mem_if.sv
// ------------------------------------------------
// Testbench for the AXI4 SRAM slave
// Models the stallable single-port memory, drives
// AXI bursts on the falling edge and checks every B
// and R transfer against a shadow of the memory
// Grant and back-pressure come from a seeded LCG
// ------------------------------------------------

module tb_axi_mem_if;

    localparam int          MEM_AW    = 10;
    localparam int          MEM_WORDS = 1 << MEM_AW;
    localparam int          TIMEOUT   = 5000;
    localparam logic [31:0] SEED      = 32'h22e8f95b;

    logic                  ACLK;
    logic                  ARESETn;
    axi_mem_pkg::axi_aw_t  aw_i;
    logic                  aw_valid_i;
    logic                  aw_ready_o;
    axi_mem_pkg::axi_w_t   w_i;
    logic                  w_valid_i;
    logic                  w_ready_o;
    axi_mem_pkg::axi_b_t   b_o;
    logic                  b_valid_o;
    logic                  b_ready_i;
    axi_mem_pkg::axi_ar_t  ar_i;
    logic                  ar_valid_i;
    logic                  ar_ready_o;
    axi_mem_pkg::axi_r_t   r_o;
    logic                  r_valid_o;
    logic                  r_ready_i;
    axi_mem_pkg::mem_req_t mem_req_o;
    logic                  mem_gnt_i;
    logic [31:0]           mem_rdata_i;

    logic [31:0]           mem [0:MEM_WORDS-1];
    logic [31:0]           shadow [0:MEM_WORDS-1];
    logic [31:0]           rd_word;
    logic [31:0]           stim_state;
    logic [31:0]           bp_state;
    axi_mem_pkg::axi_b_t   exp_b_q [$];
    axi_mem_pkg::axi_r_t   exp_r_q [$];
    string                 test_name;
    int                    b_errors;
    int                    r_errors;
    int                    mem_errors;
    int                    other_errors;

    axi_mem_if_top #(
        .MEM_ADDR_WIDTH ( MEM_AW )
    ) i_dut (
        .ACLK        ( ACLK        ),
        .ARESETn     ( ARESETn     ),
        .aw_i        ( aw_i        ),
        .aw_valid_i  ( aw_valid_i  ),
        .aw_ready_o  ( aw_ready_o  ),
        .w_i         ( w_i         ),
        .w_valid_i   ( w_valid_i   ),
        .w_ready_o   ( w_ready_o   ),
        .b_o         ( b_o         ),
        .b_valid_o   ( b_valid_o   ),
        .b_ready_i   ( b_ready_i   ),
        .ar_i        ( ar_i        ),
        .ar_valid_i  ( ar_valid_i  ),
        .ar_ready_o  ( ar_ready_o  ),
        .r_o         ( r_o         ),
        .r_valid_o   ( r_valid_o   ),
        .r_ready_i   ( r_ready_i   ),
        .mem_req_o   ( mem_req_o   ),
        .mem_gnt_i   ( mem_gnt_i   ),
        .mem_rdata_i ( mem_rdata_i )
    );

    initial
    begin
        ACLK = 1'b0;
        forever #50 ACLK = ~ACLK;
    end

    // ------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(input int unsigned i);
        return (32'(i) * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic logic addr_in_range(input logic [31:0] addr);
        return (addr >> (MEM_AW + 2)) == 32'd0;
    endfunction

    // Expected word at a byte address, zero outside the memory
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (!addr_in_range(addr))
            return 32'd0;
        return shadow[addr[MEM_AW+1:2]];
    endfunction

    function automatic void shadow_write(input logic [31:0] addr, input logic [31:0] data,
                                         input logic [3:0] strb);
        logic [31:0] w;
        if (!addr_in_range(addr))
            return;
        w = shadow[addr[MEM_AW+1:2]];
        for (int b = 0; b < 4; b++)
            if (strb[b])
                w[8*b +: 8] = data[8*b +: 8];
        shadow[addr[MEM_AW+1:2]] = w;
    endfunction

    task automatic stim_rand(output logic [31:0] v);
        stim_state = lcg_step(stim_state);
        v = stim_state;
    endtask

    task automatic timeout_error(input string what);
        other_errors++;
        $display("Timeout in test %s: %s", test_name, what);
    endtask

    task automatic check_b(input axi_mem_pkg::axi_b_t exp, input axi_mem_pkg::axi_b_t act);
        if (act !== exp)
        begin
            b_errors++;
            $display("CHECK FAILED %s: B expected id=%h resp=%h, actual id=%h resp=%h",
                     test_name, exp.id, exp.resp, act.id, act.resp);
        end
    endtask

    task automatic check_r(input axi_mem_pkg::axi_r_t exp, input axi_mem_pkg::axi_r_t act);
        if (act !== exp)
        begin
            r_errors++;
            $display({"CHECK FAILED %s: R expected id=%h data=%h resp=%h last=%b, ",
                      "actual id=%h data=%h resp=%h last=%b"},
                     test_name, exp.id, exp.data, exp.resp, exp.last,
                     act.id, act.data, act.resp, act.last);
        end
    endtask

    task automatic check_word(input int idx, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            mem_errors++;
            $display("CHECK FAILED %s: word %0d expected %h actual %h", test_name, idx, exp, act);
        end
    endtask

    // ------------------------------------------------
    // Memory model and random handshakes
    // ------------------------------------------------
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(i);
        rd_word = '0;
        forever
        begin
            @(posedge ACLK);
            if (!mem_req_o.cen_n && mem_gnt_i)
            begin
                if (!mem_req_o.wen_n)
                begin
                    for (int b = 0; b < 4; b++)
                        if (mem_req_o.be[b])
                            mem[mem_req_o.addr[MEM_AW-1:0]][8*b +: 8] =
                                mem_req_o.wdata[8*b +: 8];
                end
                else
                    rd_word = mem[mem_req_o.addr[MEM_AW-1:0]];
            end
        end
    end

    initial
    begin
        mem_gnt_i   = 1'b0;
        r_ready_i   = 1'b0;
        b_ready_i   = 1'b0;
        mem_rdata_i = '0;
        bp_state    = SEED;
        forever
        begin
            @(negedge ACLK);
            bp_state    = lcg_step(bp_state);
            // Each handshake is high about three cycles in four
            mem_gnt_i   = bp_state[31:30] != 2'b00;
            r_ready_i   = bp_state[29:28] != 2'b00;
            b_ready_i   = bp_state[27:26] != 2'b00;
            mem_rdata_i = rd_word;
        end
    end

    // Compare process for B and R transfers
    always @(posedge ACLK)
    begin
        if (ARESETn && b_valid_o && b_ready_i)
        begin
            if (exp_b_q.size() == 0)
            begin
                other_errors++;
                $display("Unexpected B response in test %s with no write outstanding", test_name);
            end
            else
                check_b(exp_b_q.pop_front(), b_o);
        end
        if (ARESETn && r_valid_o && r_ready_i)
        begin
            if (exp_r_q.size() == 0)
            begin
                other_errors++;
                $display("Unexpected R beat in test %s with no read outstanding", test_name);
            end
            else
                check_r(exp_r_q.pop_front(), r_o);
        end
    end

    // ------------------------------------------------
    // Burst stimulus
    // ------------------------------------------------
    task automatic write_burst(input logic [31:0] addr, input int len,
                               input axi_mem_pkg::burst_e burst, input logic [3:0] id,
                               input logic [3:0] strb, input logic rand_strb);
        axi_mem_pkg::axi_b_t exp_b;
        logic [31:0]         a;
        logic [31:0]         rnd;
        logic [3:0]          s;
        logic                bad;
        logic                acc;
        int                  t;
        // One bad beat turns the whole burst into SLVERR
        a   = addr;
        bad = 1'b0;
        for (int i = 0; i <= len; i++)
        begin
            bad = bad | !addr_in_range(a);
            if (burst == axi_mem_pkg::BURST_INCR)
                a = a + 32'd4;
        end
        exp_b.id   = id;
        exp_b.resp = bad ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
        exp_b_q.push_back(exp_b);

        @(negedge ACLK);
        aw_i.id    = id;
        aw_i.addr  = addr;
        aw_i.len   = 8'(len);
        aw_i.burst = burst;
        aw_valid_i = 1'b1;
        t   = 0;
        acc = 1'b0;
        while (!acc && t < TIMEOUT)
        begin
            @(posedge ACLK);
            acc = aw_ready_o;
            t++;
        end
        if (!acc)
            timeout_error("AW was never accepted");
        @(negedge ACLK);
        aw_valid_i = 1'b0;

        a = addr;
        for (int i = 0; i <= len; i++)
        begin
            stim_rand(rnd);
            s          = rand_strb ? rnd[27:24] : strb;
            w_i.data   = rnd;
            w_i.strb   = s;
            w_i.last   = (i == len);
            w_valid_i  = 1'b1;
            t   = 0;
            acc = 1'b0;
            while (!acc && t < TIMEOUT)
            begin
                @(posedge ACLK);
                acc = w_ready_o;
                t++;
            end
            if (acc)
                shadow_write(a, rnd, s);
            else
                timeout_error("W beat was never accepted");
            if (burst == axi_mem_pkg::BURST_INCR)
                a = a + 32'd4;
            @(negedge ACLK);
        end
        w_valid_i = 1'b0;

        t = 0;
        while (exp_b_q.size() != 0 && t < TIMEOUT)
        begin
            @(negedge ACLK);
            t++;
        end
        if (exp_b_q.size() != 0)
            timeout_error("B response never arrived");
    endtask

    task automatic read_burst(input logic [31:0] addr, input int len,
                              input axi_mem_pkg::burst_e burst, input logic [3:0] id);
        axi_mem_pkg::axi_r_t exp_r;
        logic [31:0]         a;
        logic                acc;
        int                  t;
        a = addr;
        for (int i = 0; i <= len; i++)
        begin
            exp_r.id   = id;
            exp_r.data = ref_read(a);
            exp_r.resp = addr_in_range(a) ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
            exp_r.last = (i == len);
            exp_r_q.push_back(exp_r);
            if (burst == axi_mem_pkg::BURST_INCR)
                a = a + 32'd4;
        end

        @(negedge ACLK);
        ar_i.id    = id;
        ar_i.addr  = addr;
        ar_i.len   = 8'(len);
        ar_i.burst = burst;
        ar_valid_i = 1'b1;
        t   = 0;
        acc = 1'b0;
        while (!acc && t < TIMEOUT)
        begin
            @(posedge ACLK);
            acc = ar_ready_o;
            t++;
        end
        if (!acc)
            timeout_error("AR was never accepted");
        @(negedge ACLK);
        ar_valid_i = 1'b0;

        t = 0;
        while (exp_r_q.size() != 0 && t < TIMEOUT)
        begin
            @(negedge ACLK);
            t++;
        end
        if (exp_r_q.size() != 0)
            timeout_error("R beats never all arrived");
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial
    begin
        logic [31:0] rnd;
        logic [31:0] wr_addr;
        logic [31:0] rd_addr;
        int          wr_len;
        int          rd_len;
        ARESETn      = 1'b0;
        aw_i         = '0;
        aw_valid_i   = 1'b0;
        w_i          = '0;
        w_valid_i    = 1'b0;
        ar_i         = '0;
        ar_valid_i   = 1'b0;
        b_errors     = 0;
        r_errors     = 0;
        mem_errors   = 0;
        other_errors = 0;
        // Payload stream kept apart from the handshake stream
        stim_state   = ~SEED;
        test_name    = "reset";
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = fill_word(i);
        repeat (16) @(negedge ACLK);
        ARESETn = 1'b1;

        test_name = "single";
        write_burst(32'h10, 0, axi_mem_pkg::BURST_INCR, 4'h3, 4'hF, 1'b0);
        read_burst(32'h10, 0, axi_mem_pkg::BURST_INCR, 4'h5);

        test_name = "strobe";
        write_burst(32'h20, 0, axi_mem_pkg::BURST_INCR, 4'h1, 4'hF, 1'b0);
        write_burst(32'h20, 0, axi_mem_pkg::BURST_INCR, 4'h2, 4'b0110, 1'b0);
        read_burst(32'h20, 0, axi_mem_pkg::BURST_INCR, 4'h7);

        test_name = "incr";
        write_burst(32'h400, 255, axi_mem_pkg::BURST_INCR, 4'h4, 4'hF, 1'b0);
        read_burst(32'h400, 255, axi_mem_pkg::BURST_INCR, 4'h9);
        stim_rand(rnd);
        wr_len = int'(rnd[31:24]);
        write_burst(32'hC00, wr_len, axi_mem_pkg::BURST_INCR, 4'hA, 4'h0, 1'b1);
        read_burst(32'hC00, wr_len, axi_mem_pkg::BURST_INCR, 4'hB);

        test_name = "fixed";
        write_burst(32'h80, 7, axi_mem_pkg::BURST_FIXED, 4'h6, 4'h0, 1'b1);
        read_burst(32'h80, 0, axi_mem_pkg::BURST_INCR, 4'h6);
        read_burst(32'h80, 3, axi_mem_pkg::BURST_FIXED, 4'h8);

        // 0x10040 aliases word 0x40 if the upper bits were dropped
        test_name = "range";
        write_burst(32'h0001_0040, 1, axi_mem_pkg::BURST_INCR, 4'hC, 4'hF, 1'b0);
        read_burst(32'h0001_0040, 1, axi_mem_pkg::BURST_INCR, 4'hD);
        write_burst(32'hFF8, 3, axi_mem_pkg::BURST_INCR, 4'hE, 4'hF, 1'b0);
        read_burst(32'hFF8, 3, axi_mem_pkg::BURST_INCR, 4'hF);
        read_burst(32'h40, 0, axi_mem_pkg::BURST_INCR, 4'h0);

        // Writes stay in 0x800 and up, reads below 0x800
        test_name = "concurrent";
        for (int n = 0; n < 8; n++)
        begin
            stim_rand(rnd);
            wr_len  = int'(rnd[31:28]);
            rd_len  = int'(rnd[27:24]);
            wr_addr = 32'h800 | {22'h0, rnd[23:16], 2'b00};
            rd_addr = {22'h0, rnd[15:8], 2'b00};
            fork
                write_burst(wr_addr, wr_len, axi_mem_pkg::BURST_INCR, rnd[7:4], 4'h0, 1'b1);
                read_burst(rd_addr, rd_len, axi_mem_pkg::BURST_INCR, ~rnd[7:4]);
            join
        end

        test_name = "memory";
        for (int i = 0; i < MEM_WORDS; i++)
            check_word(i, shadow[i], mem[i]);

        $display("Error counts: B %0d, R %0d, memory %0d, other %0d",
                 b_errors, r_errors, mem_errors, other_errors);
        if (b_errors + r_errors + mem_errors + other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: compile.f
hw/axi_mem_pkg.sv
hw/axi_write_ctrl.sv
hw/axi_read_ctrl.sv
hw/mem_port_arbiter.sv
hw/axi_mem_if_top.sv
dv/tb_axi_mem_if.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_axi_mem_if -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -qx "TB PASSED" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
